/* design/isaPkg.sv */
// miniCore instruction set definitions
`default_nettype none

package isaPkg;

    typedef logic [15:0] word_t;    // Data or address word
    typedef logic [2:0]  regSel_t;  // One of eight registers
    typedef logic [4:0]  opcode_t;  // Instr[15:11]

    typedef enum logic [1:0] {
        aluAdd  = 2'b00,
        aluSub  = 2'b01,            // opA - opB
        aluXor  = 2'b10,
        aluPass = 2'b11             // Forward opB, used by lbi
    } aluOp_t;

    // Supported opcodes
    localparam opcode_t opHalt = 5'b00000;
    localparam opcode_t opJ    = 5'b00100;  // J-format
    localparam opcode_t opJal  = 5'b00110;  // J-format, links to r7
    localparam opcode_t opBeqz = 5'b01100;  // I-format 2
    localparam opcode_t opLbi  = 5'b11000;  // I-format 2
    localparam opcode_t opAddi = 5'b01000;  // I-format 1
    localparam opcode_t opSubi = 5'b01001;  // I-format 1
    localparam opcode_t opXori = 5'b01010;  // I-format 1, zero extended imm
    localparam opcode_t opRfmt = 5'b11011;  // add, sub, xor by Instr[1:0]

    localparam logic [1:0] fnAdd = 2'b00;  // R-format ext field
    localparam logic [1:0] fnSub = 2'b01;
    localparam logic [1:0] fnXor = 2'b10;

    localparam regSel_t linkReg = 3'd7;    // jal return address

    typedef enum logic [2:0] {
        stFetch     = 3'd0,
        stDecode    = 3'd1,
        stExecute   = 3'd2,
        stWriteback = 3'd3,
        stHalt      = 3'd4
    } coreState_t;

endpackage

`default_nettype wire

/* design/controlFsm.sv */
// Instruction sequencing FSM
`timescale 1ns/1ns
`default_nettype none

module controlFsm import isaPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  opcode_t    opcode,       // From latched instruction
    input  logic [1:0] funct,        // R-format ext field
    input  logic       operandZero,  // Rs == 0, for beqz
    output logic       instrLatch,   // Fetch strobe
    output logic       regWrite,     // Writeback strobe
    output logic       pcLoadRel,
    output logic       pcStep,
    output logic       aluSrc,       // 1 selects immediate as opB
    output aluOp_t     aluOp,
    output logic       i1Fmt,
    output logic       regDst,       // Rd field as destination
    output logic       zeroExt,
    output logic       isLink,
    output logic       isBranch,
    output logic       isJump,
    output logic       halted
);

    coreState_t state, stateNext;
    logic       writesReg;  // Instruction has a destination register

    always_comb begin
        case (state)
            stFetch:     stateNext = stDecode;
            stDecode:    stateNext = (opcode == opHalt) ? stHalt : stExecute;
            stExecute:   stateNext = stWriteback;
            stWriteback: stateNext = stFetch;
            default:     stateNext = stHalt;  // Parked until reset
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stFetch;
        end else begin
            state <= stateNext;
        end
    end

    // Control word captured at the end of decode, held to writeback
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aluSrc    <= 1'b0;
            aluOp     <= aluAdd;
            i1Fmt     <= 1'b0;
            regDst    <= 1'b0;
            zeroExt   <= 1'b0;
            isLink    <= 1'b0;
            isBranch  <= 1'b0;
            isJump    <= 1'b0;
            writesReg <= 1'b0;
        end else if (state == stDecode) begin
            aluSrc    <= 1'b0;    // Defaults act as a nop
            aluOp     <= aluAdd;
            i1Fmt     <= 1'b0;
            regDst    <= 1'b0;
            zeroExt   <= 1'b0;
            isLink    <= 1'b0;
            isBranch  <= 1'b0;
            isJump    <= 1'b0;
            writesReg <= 1'b0;
            case (opcode)
                opRfmt: begin
                    regDst    <= 1'b1;
                    writesReg <= 1'b1;
                    case (funct)
                        fnSub:   aluOp <= aluSub;
                        fnXor:   aluOp <= aluXor;
                        default: aluOp <= aluAdd;  // fnAdd
                    endcase
                end
                opAddi, opSubi, opXori: begin
                    i1Fmt     <= 1'b1;
                    aluSrc    <= 1'b1;
                    writesReg <= 1'b1;
                    zeroExt   <= (opcode == opXori);  // Logical imm is unsigned
                    aluOp     <= (opcode == opAddi) ? aluAdd :
                                 (opcode == opSubi) ? aluSub : aluXor;
                end
                opLbi: begin
                    aluSrc    <= 1'b1;
                    aluOp     <= aluPass;  // Rs <- sext(imm8)
                    writesReg <= 1'b1;
                end
                opBeqz:  isBranch <= 1'b1;
                opJ:     isJump   <= 1'b1;
                opJal: begin
                    isJump    <= 1'b1;
                    isLink    <= 1'b1;
                    writesReg <= 1'b1;
                end
                default: ;  // halt leaves, others run as nop
            endcase
        end
    end

    assign instrLatch = (state == stFetch);
    assign regWrite   = (state == stWriteback) && writesReg;
    assign pcLoadRel  = (state == stWriteback) && (isJump || (isBranch && operandZero));
    assign pcStep     = (state == stWriteback) && !pcLoadRel;
    assign halted     = (state == stHalt);

endmodule

`default_nettype wire

/* design/pcCounter.sv */
// Program counter
`timescale 1ns/1ns
`default_nettype none

module pcCounter import isaPkg::*; #(
    parameter word_t resetPc = 16'h0000
) (
    input  logic  clk,
    input  logic  arstN,
    input  logic  pcStep,     // Sequential step
    input  logic  pcLoadRel,  // Jump or taken branch
    input  word_t offset,     // Relative to pc + 2
    output word_t pc,
    output word_t pcNext      // pc + 2, also the jal link value
);

    word_t target;

    assign pcNext = pc + 16'd2;
    assign target = pcNext + offset;  // Wraps within 16 bits

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else if (pcLoadRel) begin
            pc <= target;
        end else if (pcStep) begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* design/regFile.sv */
// Eight entry register file
`timescale 1ns/1ns
`default_nettype none

module regFile import isaPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  regSel_t read1Sel,
    input  regSel_t read2Sel,
    input  regSel_t writeSel,
    input  word_t   writeData,
    input  logic    writeEn,
    output word_t   read1Data,
    output word_t   read2Data
);

    word_t regs [8];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;  // All registers start at zero
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Reads are asynchronous and never overlap a write in this core
    assign read1Data = regs[read1Sel];
    assign read2Data = regs[read2Sel];

endmodule

`default_nettype wire

/* design/decode.sv */
// Decode stage with register file
`timescale 1ns/1ns
`default_nettype none

module decode import isaPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  word_t      instr,        // From instruction memory
    input  logic       instrLatch,
    input  logic       regWrite,
    input  logic       regDst,
    input  logic       i1Fmt,
    input  logic       zeroExt,
    input  logic       isLink,
    input  word_t      writeData,    // ALU result
    output word_t      readData1,    // Rs
    output word_t      readData2,    // Rt in R-format
    output word_t      immVal,
    output word_t      jumpDist,     // J-format displacement
    output regSel_t    writeRegOut,
    output opcode_t    opcode,
    output logic [1:0] funct
);

    word_t   instrQ;   // Current instruction
    regSel_t rsSel;
    regSel_t rtSel;
    regSel_t rdSel;
    word_t   immI1Sext;
    word_t   immI1Zext;
    word_t   immI2Sext;

    always_ff @(posedge clk) begin
        if (instrLatch) begin
            instrQ <= instr;  // Captured in the fetch cycle
        end
    end

    // Field layout
    //   R   opc[15:11] Rs[10:8] Rt[7:5] Rd[4:2] ext[1:0]
    //   I1  opc Rs Rd[7:5] imm5[4:0]
    //   I2  opc Rs imm8[7:0]
    //   J   opc disp11[10:0]
    assign opcode = instrQ[15:11];
    assign rsSel  = instrQ[10:8];
    assign rtSel  = instrQ[7:5];
    assign rdSel  = instrQ[4:2];
    assign funct  = instrQ[1:0];

    always_comb begin
        if (isLink) begin
            writeRegOut = linkReg;  // jal
        end else if (i1Fmt) begin
            writeRegOut = rtSel;    // Second field is Rd in I-format 1
        end else if (regDst) begin
            writeRegOut = rdSel;    // R-format
        end else begin
            writeRegOut = rsSel;    // lbi
        end
    end

    regFile uRegFile (
        .clk       (clk),
        .arstN     (arstN),
        .read1Sel  (rsSel),
        .read2Sel  (rtSel),
        .writeSel  (writeRegOut),
        .writeData (writeData),
        .writeEn   (regWrite),
        .read1Data (readData1),
        .read2Data (readData2)
    );

    assign immI1Sext = {{11{instrQ[4]}}, instrQ[4:0]};
    assign immI1Zext = {11'b0, instrQ[4:0]};
    assign immI2Sext = {{8{instrQ[7]}}, instrQ[7:0]};

    always_comb begin
        case ({i1Fmt, zeroExt})
            2'b11:   immVal = immI1Zext;  // xori
            2'b10:   immVal = immI1Sext;  // addi, subi
            default: immVal = immI2Sext;  // lbi, beqz
        endcase
    end

    assign jumpDist = {{5{instrQ[10]}}, instrQ[10:0]};

endmodule

`default_nettype wire

/* design/alu.sv */
// Arithmetic and logic unit
`timescale 1ns/1ns
`default_nettype none

module alu import isaPkg::*; (
    input  word_t  opA,          // Rs
    input  word_t  opB,          // Rt or immediate
    input  aluOp_t aluOp,
    input  logic   linkSel,      // jal writes the return address
    input  word_t  linkValue,
    output word_t  result,
    output logic   operandZero   // Rs test for beqz
);

    word_t opResult;

    always_comb begin
        case (aluOp)
            aluAdd:  opResult = opA + opB;
            aluSub:  opResult = opA - opB;
            aluXor:  opResult = opA ^ opB;
            default: opResult = opB;  // aluPass
        endcase
    end

    assign result      = linkSel ? linkValue : opResult;
    assign operandZero = (opA == 16'h0000);

endmodule

`default_nettype wire

/* design/miniCore.sv */
// miniCore top level
`timescale 1ns/1ns
`default_nettype none

module miniCore import isaPkg::*; #(
    parameter word_t resetPc = 16'h0000
) (
    input  logic    clk,
    input  logic    arstN,
    input  word_t   instr,         // Combinational memory reply
    output word_t   instrAddr,
    output logic    regWriteEn,
    output regSel_t regWriteSel,
    output word_t   regWriteData,
    output logic    halted
);

    opcode_t    opcode;
    logic [1:0] funct;
    logic       instrLatch;
    logic       pcLoadRel;
    logic       pcStep;
    logic       aluSrc;
    aluOp_t     aluOp;
    logic       i1Fmt;
    logic       regDst;
    logic       zeroExt;
    logic       isLink;
    logic       isBranch;
    logic       isJump;
    logic       operandZero;
    word_t      readData1;
    word_t      readData2;
    word_t      immVal;
    word_t      jumpDist;
    word_t      aluB;
    word_t      pcNext;
    word_t      pcOffset;

    assign aluB     = aluSrc ? immVal : readData2;
    assign pcOffset = ({16{isJump}} & jumpDist) | ({16{isBranch}} & immVal);  // One-hot

    controlFsm uFsm (
        .clk (clk), .arstN (arstN), .opcode (opcode), .funct (funct),
        .operandZero (operandZero), .instrLatch (instrLatch), .regWrite (regWriteEn),
        .pcLoadRel (pcLoadRel), .pcStep (pcStep), .aluSrc (aluSrc), .aluOp (aluOp),
        .i1Fmt (i1Fmt), .regDst (regDst), .zeroExt (zeroExt), .isLink (isLink),
        .isBranch (isBranch), .isJump (isJump), .halted (halted)
    );

    pcCounter #(.resetPc(resetPc)) uPc (
        .clk (clk), .arstN (arstN), .pcStep (pcStep), .pcLoadRel (pcLoadRel),
        .offset (pcOffset), .pc (instrAddr), .pcNext (pcNext)
    );

    decode uDecode (
        .clk (clk), .arstN (arstN), .instr (instr), .instrLatch (instrLatch),
        .regWrite (regWriteEn), .regDst (regDst), .i1Fmt (i1Fmt), .zeroExt (zeroExt),
        .isLink (isLink), .writeData (regWriteData), .readData1 (readData1),
        .readData2 (readData2), .immVal (immVal), .jumpDist (jumpDist),
        .writeRegOut (regWriteSel), .opcode (opcode), .funct (funct)
    );

    alu uAlu (
        .opA (readData1), .opB (aluB), .aluOp (aluOp), .linkSel (isLink),
        .linkValue (pcNext), .result (regWriteData), .operandZero (operandZero)
    );

endmodule

`default_nettype wire

/* sim/tbClock.sv */
// Testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
    parameter int periodNs    = 100,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;                          // Asserted from time zero
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;                         // Released on a rising edge
    end

endmodule

`default_nettype wire

/* sim/coreChecker.sv */
// Shadow model checker for miniCore
`timescale 1ns/1ns
`default_nettype none

module coreChecker import isaPkg::*; #(
    parameter word_t resetPc = 16'h0000
) (
    input  logic    clk,
    input  logic    arstN,
    input  word_t   instr,
    input  word_t   instrAddr,
    input  logic    regWriteEn,
    input  regSel_t regWriteSel,
    input  word_t   regWriteData,
    input  logic    halted
);

    int         errorCount = 0;  // Failed assertions so far
    logic [1:0] phase;           // 0 fetch, 1 decode, 2 execute, 3 writeback
    logic       shHalted;
    word_t      shPc;
    word_t      curInstr;        // Word taken in the fetch cycle
    word_t      shReg [8];
    regSel_t    rs;
    word_t      opA;
    word_t      opB;             // Rt for R-format
    word_t      imm5s;
    word_t      imm5z;
    word_t      imm8s;
    word_t      disp11s;
    logic       expWe;
    regSel_t    expSel;
    word_t      expData;
    word_t      expNextPc;
    logic       expStrobe;

    assign rs      = curInstr[10:8];
    assign opA     = shReg[rs];
    assign opB     = shReg[curInstr[7:5]];
    assign imm5s   = {{11{curInstr[4]}}, curInstr[4:0]};
    assign imm5z   = {11'b0, curInstr[4:0]};           // xori
    assign imm8s   = {{8{curInstr[7]}}, curInstr[7:0]};
    assign disp11s = {{5{curInstr[10]}}, curInstr[10:0]};

    // Expected effect of the current instruction, by the ISA rules
    always_comb begin
        expWe     = 1'b1;
        expSel    = curInstr[7:5];                     // I-format 1 destination
        expData   = 16'h0000;
        expNextPc = shPc + 16'd2;
        case (curInstr[15:11])
            opRfmt: begin
                expSel = curInstr[4:2];
                case (curInstr[1:0])
                    fnSub:   expData = opA - opB;
                    fnXor:   expData = opA ^ opB;
                    default: expData = opA + opB;
                endcase
            end
            opAddi:  expData = opA + imm5s;
            opSubi:  expData = opA - imm5s;
            opXori:  expData = opA ^ imm5z;
            opLbi: begin
                expSel  = rs;
                expData = imm8s;
            end
            opBeqz: begin
                expWe = 1'b0;
                if (opA == 16'h0000) begin
                    expNextPc = shPc + 16'd2 + imm8s;  // Taken
                end
            end
            opJ: begin
                expWe     = 1'b0;
                expNextPc = shPc + 16'd2 + disp11s;
            end
            opJal: begin
                expSel    = linkReg;
                expData   = shPc + 16'd2;              // Return address
                expNextPc = shPc + 16'd2 + disp11s;
            end
            default: expWe = 1'b0;                     // halt
        endcase
    end

    assign expStrobe = (phase == 2'd3) && expWe && !shHalted;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase    <= 2'd0;
            shHalted <= 1'b0;
            shPc     <= resetPc;
            curInstr <= 16'h0000;
            for (int i = 0; i < 8; i++) begin
                shReg[i] <= 16'h0000;
            end
        end else if (!shHalted) begin
            case (phase)
                2'd0: curInstr <= instr;
                2'd1: shHalted <= (curInstr[15:11] == opHalt);  // Parks after decode
                2'd3: begin
                    if (expWe) begin
                        shReg[expSel] <= expData;
                    end
                    shPc <= expNextPc;
                end
                default: ;
            endcase
            phase <= phase + 2'd1;
        end
    end

    // Checked from the second reset cycle, once the reset has taken hold
    resetState: assert property (@(posedge clk)
        (!arstN && $past(!arstN)) |-> (instrAddr == resetPc && !regWriteEn && !halted))
    else begin
        errorCount++;
        $error("mismatch resetState expected %h actual %h (regWriteEn %b halted %b)",
               resetPc, $sampled(instrAddr), $sampled(regWriteEn), $sampled(halted));
    end

    fetchAddr: assert property (@(posedge clk) disable iff (!arstN)
        (phase == 2'd0 && !shHalted) |-> instrAddr == shPc)
    else begin
        errorCount++;
        $error("mismatch fetchAddr expected %h actual %h", $sampled(shPc), $sampled(instrAddr));
    end

    // Strobe only in the fourth cycle and only for writing instructions
    writeStrobe: assert property (@(posedge clk) disable iff (!arstN)
        regWriteEn == expStrobe)
    else begin
        errorCount++;
        $error("mismatch writeStrobe expected %b actual %b",
               $sampled(expStrobe), $sampled(regWriteEn));
    end

    writeSel: assert property (@(posedge clk) disable iff (!arstN)
        regWriteEn |-> regWriteSel == expSel)
    else begin
        errorCount++;
        $error("mismatch writeSel expected %0d actual %0d",
               $sampled(expSel), $sampled(regWriteSel));
    end

    writeData: assert property (@(posedge clk) disable iff (!arstN)
        regWriteEn |-> regWriteData == expData)
    else begin
        errorCount++;
        $error("mismatch writeData expected %h actual %h",
               $sampled(expData), $sampled(regWriteData));
    end

    haltFlag: assert property (@(posedge clk) disable iff (!arstN)
        halted == shHalted)
    else begin
        errorCount++;
        $error("mismatch haltFlag expected %b actual %b", $sampled(shHalted), $sampled(halted));
    end

    haltHold: assert property (@(posedge clk) disable iff (!arstN)
        halted |=> (halted && $stable(instrAddr)))
    else begin
        errorCount++;
        $error("halted dropped or instrAddr moved after the core halted");
    end

endmodule

`default_nettype wire

/* sim/tbTop.sv */
// miniCore testbench top
`timescale 1ns/1ns
`default_nettype none

module tbTop import isaPkg::*; ();

    localparam logic [31:0] seed       = 32'h6bdd;
    localparam int          progWords  = 64;
    localparam int          cycleLimit = 400;        // 64 x 4 cycles, reset and margin
    localparam word_t       startPc    = 16'h0100;

    logic    clk;
    logic    arstN;
    word_t   instr;
    word_t   instrAddr;
    logic    regWriteEn;
    regSel_t regWriteSel;
    word_t   regWriteData;
    logic    halted;
    word_t   imem [progWords];
    word_t   memOffset;
    int      cycleCount = 0;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // One program word, kind rotates with the index so every kind appears
    function automatic word_t makeInstr(input int idx, input logic [31:0] rnd);
        logic [1:0] fn;
        logic [2:0] skip;
        logic [7:0] disp;
        word_t      w;
        fn   = (rnd[22:21] == 2'd3) ? fnAdd : rnd[22:21];
        skip = {1'b0, rnd[20:19]};                   // Words jumped over
        if (int'(skip) > 62 - idx) begin
            skip = 3'(62 - idx);                     // Stay before the halt word
        end
        disp = {4'b0, skip, 1'b0};
        case (idx % 8)
            0:       w = {opRfmt, rnd[31:29], rnd[28:26], rnd[25:23], fn};
            1:       w = {opAddi, rnd[31:29], rnd[28:26], rnd[15:11]};
            2:       w = {opSubi, rnd[31:29], rnd[28:26], rnd[15:11]};
            3:       w = {opXori, rnd[31:29], rnd[28:26], rnd[15:11]};
            4:       w = {opLbi, rnd[31:29], rnd[18:11]};
            5:       w = {opBeqz, rnd[31:29], disp};
            6:       w = {opJ, 3'b000, disp};
            default: w = {opJal, 3'b000, disp};
        endcase
        return w;
    endfunction

    tbClock #(.periodNs(100), .resetCycles(16)) uClock (.clk(clk), .arstN(arstN));

    assign memOffset = instrAddr - startPc;
    assign instr     = imem[memOffset[6:1]];         // Combinational memory reply

    miniCore #(.resetPc(startPc)) u_dut (
        .clk (clk), .arstN (arstN), .instr (instr), .instrAddr (instrAddr),
        .regWriteEn (regWriteEn), .regWriteSel (regWriteSel),
        .regWriteData (regWriteData), .halted (halted)
    );

    bind miniCore coreChecker #(.resetPc(resetPc)) u_chk (
        .clk (clk), .arstN (arstN), .instr (instr), .instrAddr (instrAddr),
        .regWriteEn (regWriteEn), .regWriteSel (regWriteSel),
        .regWriteData (regWriteData), .halted (halted)
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("CHECKS FAILED");
            $fatal(1, "timeout, halted did not rise within %0d cycles", cycleLimit);
        end
    end

    // First failed assertion ends the run
    always @(negedge clk) begin
        if (u_dut.u_chk.errorCount != 0) begin
            $display("CHECKS FAILED");
            $fatal(1, "checker assertion failed, see the error line above");
        end
    end

    initial begin
        logic [31:0] rnd;
        rnd = seed;
        for (int i = 0; i < progWords - 1; i++) begin
            rnd = lcgNext(rnd);
            imem[6'(i)] = makeInstr(i, rnd);
        end
        imem[6'(progWords - 1)] = {opHalt, 11'b0};
        wait (halted === 1'b1);
        repeat (4) @(posedge clk);                   // Watch the parked core a while
        @(negedge clk);
        if (u_dut.u_chk.errorCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "%0d checker assertions failed", u_dut.u_chk.errorCount);
        end
    end

endmodule

`default_nettype wire

/* miniCore.f */
design/isaPkg.sv
design/controlFsm.sv
design/pcCounter.sv
design/regFile.sv
design/decode.sv
design/alu.sv
design/miniCore.sv
sim/tbClock.sv
sim/coreChecker.sv
sim/tbTop.sv

/* Makefile */
# Verilator build and run for the miniCore testbench

SRCS := $(wildcard design/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: obj_dir/VtbTop

obj_dir/VtbTop: miniCore.f $(SRCS)
	verilator --binary --timing --assert --top-module tbTop -f miniCore.f

# Assertion errors are counted by the testbench, which ends the run with $fatal
run: obj_dir/VtbTop
	./obj_dir/VtbTop +verilator+error+limit+100

clean:
	rm -rf obj_dir
